//--- IssueUnit.f
source/IssuePkg.sv
source/IssueIfs.sv
source/Picker.sv
source/IssueQueue.sv
source/ExecLane.sv
source/ResultMerger.sv
source/IssueUnit.sv
verification/IssueUnit_properties.sv
verification/IssueUnitTb.sv

//--- Makefile
# Verilator flow for the issue unit testbench.

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module IssueUnitTb \
		-f IssueUnit.f -Mdir obj_dir -o IssueUnitSim

run: compile
	./obj_dir/IssueUnitSim | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- source/ExecLane.sv
//////////////////////////////
// Integer lane.
// Single-cycle ALU with a one-deep result register.
//////////////////////////////
`timescale 1ns/1ps

module ExecLane import IssuePkg::*; (
    input logic clk,
    input logic rstN,
    LaneIssueIf.lane issue,
    LaneResultIf.lane result
);

    logic [DATA_WIDTH-1:0] aluOut;
    logic outFull;
    logic [TAG_WIDTH-1:0] outTag;
    logic [DATA_WIDTH-1:0] outValue;
    logic accept;
    logic drain;

    // ALU.
    always_comb begin
        case (issue.op.opcode)
            OP_ADD:  aluOut = issue.op.srcA + issue.op.srcB;
            OP_SUB:  aluOut = issue.op.srcA - issue.op.srcB;
            OP_AND:  aluOut = issue.op.srcA & issue.op.srcB;
            OP_OR:   aluOut = issue.op.srcA | issue.op.srcB;
            OP_XOR:  aluOut = issue.op.srcA ^ issue.op.srcB;
            OP_SHL:  aluOut = issue.op.srcA << issue.op.srcB[4:0];
            default: aluOut = '0;
        endcase
    end

    // Back-pressure point: full and not draining.
    assign drain = outFull && result.ready;
    assign issue.ready = !outFull || drain;
    assign accept = issue.valid && issue.ready;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) outFull <= 1'b0;
        else if (accept) outFull <= 1'b1;
        else if (drain) outFull <= 1'b0;
    end

    // Payload, no reset.
    always_ff @(posedge clk) begin
        if (accept) begin
            outTag <= issue.op.tag;
            outValue <= aluOut;
        end
    end

    assign result.valid = outFull;
    assign result.tag = outTag;
    assign result.value = outValue;

endmodule : ExecLane

//--- source/IssueIfs.sv
//////////////////////////////
// Lane interfaces.
// Issue path from the queue into a lane, and result path
// from a lane into the merger. Both are valid/ready.
//////////////////////////////
`timescale 1ns/1ps

interface LaneIssueIf import IssuePkg::*; ();

    logic valid;
    IssueOp op;
    logic ready;

    // Queue presents the operation, lane accepts it.
    modport queue (output valid, output op, input ready);
    modport lane (input valid, input op, output ready);

endinterface : LaneIssueIf

interface LaneResultIf import IssuePkg::*; ();

    logic valid;
    logic [TAG_WIDTH-1:0] tag;
    logic [DATA_WIDTH-1:0] value;
    logic ready;

    // Lane holds its result until the merger takes it.
    modport lane (output valid, output tag, output value, input ready);
    modport merger (input valid, input tag, input value, output ready);

endinterface : LaneResultIf

//--- source/IssuePkg.sv
//////////////////////////////
// Issue stage package.
// Sizes, opcodes and the operation record shared by the
// queue, the lanes and the top level.
//////////////////////////////
package IssuePkg;

    // Issue queue depth.
    localparam int ENTRY_NUM = 8;

    // Execution lanes, also the issue width per cycle.
    localparam int LANE_NUM = 2;

    // Operand and result width.
    localparam int DATA_WIDTH = 32;

    // Tag carried from dispatch to result.
    localparam int TAG_WIDTH = 4;

    // Index widths.
    localparam int ENTRY_PTR_WIDTH = $clog2(ENTRY_NUM);
    localparam int LANE_PTR_WIDTH = $clog2(LANE_NUM);

    // Integer lane operations.
    // OP_SHL shifts srcA left by srcB[4:0].
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SHL
    } OpCode;

    // One dispatched operation, 71 bits.
    typedef struct packed {
        OpCode opcode;
        logic [DATA_WIDTH-1:0] srcA;
        logic [DATA_WIDTH-1:0] srcB;
        logic [TAG_WIDTH-1:0] tag;
    } IssueOp;

endpackage : IssuePkg

//--- source/IssueQueue.sv
//////////////////////////////
// Issue queue.
// Eight entries, lowest-free allocation and
// lowest-valid issue to the two lanes.
//////////////////////////////
`timescale 1ns/1ps

module IssueQueue import IssuePkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic dispValid,
    input  IssueOp dispOp,
    output logic dispReady,
    LaneIssueIf.queue lanes[LANE_NUM]
);

    // Entry state.
    logic [ENTRY_NUM-1:0] entryValid;
    IssueOp entryOp[ENTRY_NUM];

    // Allocation side.
    logic [ENTRY_NUM-1:0] freeGrant;
    logic [ENTRY_PTR_WIDTH-1:0] allocPtr[1];
    logic allocGranted[1];
    logic dispFire;

    // Issue side.
    logic [ENTRY_NUM-1:0] heldMask;
    logic [ENTRY_PTR_WIDTH-1:0] pickPtr[LANE_NUM];
    logic pickGranted[LANE_NUM];
    logic [ENTRY_NUM-1:0] releaseMask;
    logic [LANE_NUM-1:0] laneValid;
    logic [LANE_NUM-1:0] laneReady;
    logic [ENTRY_PTR_WIDTH-1:0] lanePtr[LANE_NUM];

    // A lane that was stalled keeps its entry.
    logic [LANE_NUM-1:0] laneHeld;
    logic [ENTRY_PTR_WIDTH-1:0] heldPtr[LANE_NUM];

    // Free entries only; looks at registered valid bits.
    Picker #(.ENTRY_NUM(ENTRY_NUM), .GRANT_NUM(1)) allocPicker (
        .req(~entryValid), .grant(freeGrant), .grantPtr(allocPtr), .granted(allocGranted)
    );

    // Held entries are already bound to a lane.
    Picker #(.ENTRY_NUM(ENTRY_NUM), .GRANT_NUM(LANE_NUM)) issuePicker (
        .req(entryValid & ~heldMask), .grant(), .grantPtr(pickPtr), .granted(pickGranted)
    );

    assign dispReady = allocGranted[0];
    assign dispFire = dispValid && dispReady;

    always_comb begin
        heldMask = '0;
        for (int p = 0; p < LANE_NUM; p++) begin
            if (laneHeld[p]) heldMask[heldPtr[p]] = 1'b1;
        end
    end

    // Held lanes replay their entry, the others take picks in order.
    always_comb begin
        int slot;
        slot = 0;
        releaseMask = '0;
        for (int p = 0; p < LANE_NUM; p++) begin
            if (laneHeld[p]) begin
                lanePtr[p] = heldPtr[p];
                laneValid[p] = 1'b1;
            end else begin
                lanePtr[p] = pickPtr[slot];
                laneValid[p] = pickGranted[slot];
                slot++;
            end
            // Freed at the accepting edge.
            if (laneValid[p] && laneReady[p]) releaseMask[lanePtr[p]] = 1'b1;
        end
    end

    for (genvar p = 0; p < LANE_NUM; p++) begin : gLane
        assign lanes[p].valid = laneValid[p];
        assign lanes[p].op = entryOp[lanePtr[p]];
        assign laneReady[p] = lanes[p].ready;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
            laneHeld <= '0;
        end else begin
            entryValid <= (entryValid & ~releaseMask) | (dispFire ? freeGrant : '0);
            laneHeld <= laneValid & ~laneReady;
        end
    end

    always_ff @(posedge clk) begin
        if (dispFire) entryOp[allocPtr[0]] <= dispOp;
        heldPtr <= lanePtr;
    end

endmodule : IssueQueue

//--- source/IssueUnit.sv
//////////////////////////////
// Issue unit top.
// Dispatch into the issue queue, two integer lanes,
// and one merged result port.
//////////////////////////////
`timescale 1ns/1ps

module IssueUnit import IssuePkg::*; (
    input  logic clk,
    input  logic rstN,

    // Dispatch port.
    input  logic dispValid,
    input  OpCode dispOpcode,
    input  logic [DATA_WIDTH-1:0] dispSrcA,
    input  logic [DATA_WIDTH-1:0] dispSrcB,
    input  logic [TAG_WIDTH-1:0] dispTag,
    output logic dispReady,

    // Result port.
    output logic resultValid,
    output logic [TAG_WIDTH-1:0] resultTag,
    output logic [DATA_WIDTH-1:0] resultValue,
    input  logic resultReady
);

    IssueOp dispOp;

    // Queue to lane, lane to merger.
    LaneIssueIf issueIf[LANE_NUM] ();
    LaneResultIf resultIf[LANE_NUM] ();

    assign dispOp = '{opcode: dispOpcode, srcA: dispSrcA, srcB: dispSrcB, tag: dispTag};

    IssueQueue i_IssueQueue (
        .clk(clk),
        .rstN(rstN),
        .dispValid(dispValid),
        .dispOp(dispOp),
        .dispReady(dispReady),
        .lanes(issueIf)
    );

    // Identical lanes.
    for (genvar i = 0; i < LANE_NUM; i++) begin : gExec
        ExecLane i_ExecLane (
            .clk(clk),
            .rstN(rstN),
            .issue(issueIf[i]),
            .result(resultIf[i])
        );
    end

    ResultMerger i_ResultMerger (
        .clk(clk),
        .rstN(rstN),
        .lanes(resultIf),
        .resultValid(resultValid),
        .resultTag(resultTag),
        .resultValue(resultValue),
        .resultReady(resultReady)
    );

endmodule : IssueUnit

//--- source/Picker.sv
//////////////////////////////
// Picker.
// Priority encoder granting the lowest-indexed
// requests, up to GRANT_NUM of them.
//////////////////////////////
`timescale 1ns/1ps

module Picker #(
    parameter int ENTRY_NUM = 4,
    parameter int GRANT_NUM = 2
)(
    input  logic [ENTRY_NUM-1:0] req,
    output logic [ENTRY_NUM-1:0] grant,
    output logic [$clog2(ENTRY_NUM)-1:0] grantPtr[GRANT_NUM],
    output logic granted[GRANT_NUM]
);

    // Requests not yet taken by an earlier slot.
    logic [ENTRY_NUM-1:0] remaining;

    always_comb begin
        remaining = req;
        grant = '0;
        // Each slot takes the lowest request still left.
        for (int p = 0; p < GRANT_NUM; p++) begin
            granted[p] = 1'b0;
            grantPtr[p] = '0;
            for (int e = 0; e < ENTRY_NUM; e++) begin
                // First hit only, later entries are left for the next slot.
                if (remaining[e] && !granted[p]) begin
                    grant[e] = 1'b1;
                    granted[p] = 1'b1;
                    grantPtr[p] = e[$clog2(ENTRY_NUM)-1:0];
                    remaining[e] = 1'b0;
                end
            end
        end
    end

endmodule : Picker

//--- source/ResultMerger.sv
//////////////////////////////
// Result merger.
// Round-robin from the lane results onto one port.
//////////////////////////////
`timescale 1ns/1ps

module ResultMerger import IssuePkg::*; (
    input  logic clk,
    input  logic rstN,
    LaneResultIf.merger lanes[LANE_NUM],
    output logic resultValid,
    output logic [TAG_WIDTH-1:0] resultTag,
    output logic [DATA_WIDTH-1:0] resultValue,
    input  logic resultReady
);

    logic [LANE_NUM-1:0] laneValid;
    logic [TAG_WIDTH-1:0] laneTag[LANE_NUM];
    logic [DATA_WIDTH-1:0] laneValue[LANE_NUM];

    // Lane searched first; it lands on the stalled lane under back-pressure.
    logic [LANE_PTR_WIDTH-1:0] rrPtr;
    logic [LANE_PTR_WIDTH-1:0] selPtr;

    for (genvar p = 0; p < LANE_NUM; p++) begin : gLane
        assign laneValid[p] = lanes[p].valid;
        assign laneTag[p] = lanes[p].tag;
        assign laneValue[p] = lanes[p].value;
        // Only the selected lane sees the handshake.
        assign lanes[p].ready = resultReady && resultValid && (selPtr == LANE_PTR_WIDTH'(p));
    end

    always_comb begin
        int idx;
        resultValid = 1'b0;
        selPtr = rrPtr;
        for (int k = 0; k < LANE_NUM; k++) begin
            idx = (int'(rrPtr) + k) % LANE_NUM;
            if (!resultValid && laneValid[idx]) begin
                resultValid = 1'b1;
                selPtr = LANE_PTR_WIDTH'(idx);
            end
        end
        resultTag = laneTag[selPtr];
        resultValue = laneValue[selPtr];
    end

    // Advance past the served lane on a transfer; pin the lane on a stall.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) rrPtr <= '0;
        else if (resultValid && resultReady) rrPtr <= LANE_PTR_WIDTH'((int'(selPtr) + 1) % LANE_NUM);
        else if (resultValid) rrPtr <= selPtr;
    end

endmodule : ResultMerger

//--- verification/IssueUnitTb.sv
//////////////////////////////
// Issue unit testbench.
// Table-driven dispatch, a tag scoreboard and
// result back-pressure from an LCG.
//////////////////////////////
`timescale 1ns/1ps

module IssueUnitTb import IssuePkg::*; ();

    localparam int ROW_NUM = 16;
    localparam int TIMEOUT = 200;
    // Lane output registers plus queue entries.
    localparam int CAPACITY = ENTRY_NUM + LANE_NUM;

    typedef struct packed {
        OpCode op;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] exp;
    } Row;

    logic clk;
    logic rstN;
    logic dispValid;
    OpCode dispOpcode;
    logic [DATA_WIDTH-1:0] dispSrcA;
    logic [DATA_WIDTH-1:0] dispSrcB;
    logic [TAG_WIDTH-1:0] dispTag;
    logic dispReady;
    logic resultValid;
    logic [TAG_WIDTH-1:0] resultTag;
    logic [DATA_WIDTH-1:0] resultValue;
    logic resultReady;

    int errors;
    int resultCount;
    int rowCount;
    // 0 keeps ready high, 1 holds it low, 2 follows the LCG.
    int readyMode;
    logic [31:0] lcgState;
    bit seen[ROW_NUM];

    // Columns are opcode, srcA, srcB and the expected result.
    // Row index doubles as the tag.
    Row stimTable[ROW_NUM] = '{
        '{OP_ADD, 32'h0000_0005, 32'h0000_0003, 32'h0000_0008},
        '{OP_SUB, 32'h0000_0010, 32'h0000_0001, 32'h0000_000F},
        '{OP_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h00F0_1200},
        '{OP_OR,  32'h1200_0034, 32'h0045_0600, 32'h1245_0634},
        '{OP_XOR, 32'hAAAA_5555, 32'hFFFF_0000, 32'h5555_5555},
        '{OP_SHL, 32'h0000_0001, 32'h0000_001F, 32'h8000_0000},
        '{OP_ADD, 32'hFFFF_FFFF, 32'h0000_0002, 32'h0000_0001},
        '{OP_SUB, 32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF},
        '{OP_SHL, 32'h1234_5678, 32'hFFFF_FFE4, 32'h2345_6780},
        '{OP_XOR, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 32'h0000_0000},
        '{OP_OR,  32'h0000_0000, 32'h8000_0001, 32'h8000_0001},
        '{OP_AND, 32'hFFFF_FFFF, 32'h5A5A_C3C3, 32'h5A5A_C3C3},
        '{OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000},
        '{OP_SHL, 32'hFFFF_FFFF, 32'h0000_0020, 32'hFFFF_FFFF},
        '{OP_SUB, 32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_0001},
        '{OP_XOR, 32'h0F0F_0F0F, 32'h00FF_00FF, 32'h0FF0_0FF0}
    };

    IssueUnit i_IssueUnit (
        .clk(clk),
        .rstN(rstN),
        .dispValid(dispValid),
        .dispOpcode(dispOpcode),
        .dispSrcA(dispSrcA),
        .dispSrcB(dispSrcB),
        .dispTag(dispTag),
        .dispReady(dispReady),
        .resultValid(resultValid),
        .resultTag(resultTag),
        .resultValue(resultValue),
        .resultReady(resultReady)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] nextRand(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic reportAndFinish();
        $display("Run finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic abortOnTimeout(input string what);
        errors++;
        $display("Timeout while waiting for %s", what);
        reportAndFinish();
    endtask

    // Called one ns after a rising edge; returns at the same phase.
    task automatic dispatchRow(input int row);
        int cycles;
        cycles = 0;
        dispValid = 1'b1;
        dispOpcode = stimTable[row].op;
        dispSrcA = stimTable[row].a;
        dispSrcB = stimTable[row].b;
        dispTag = TAG_WIDTH'(row);
        @(negedge clk);
        while (!dispReady) begin
            cycles++;
            if (cycles > TIMEOUT) abortOnTimeout("dispReady");
            @(negedge clk);
        end
        // Transfer at the coming edge.
        @(posedge clk);
        #1;
        dispValid = 1'b0;
    endtask

    task automatic startTest(input int rows);
        foreach (seen[t]) seen[t] = 1'b0;
        resultCount = 0;
        rowCount = rows;
    endtask

    // Drain all results, then look for missing tags.
    task automatic finishTest();
        int cycles;
        cycles = 0;
        while (resultCount < rowCount) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) abortOnTimeout("resultValid");
        end
        @(posedge clk);
        #1;
        for (int t = 0; t < rowCount; t++) begin
            if (!seen[t]) begin
                errors++;
                $display("Result for tag %0d never arrived", t);
            end
        end
    endtask

    // Back-pressure driver; the mode is taken at the edge.
    always @(posedge clk) begin : readyDriver
        int mode;
        mode = readyMode;
        #1;
        if (mode == 1) begin
            resultReady = 1'b0;
        end else if (mode == 2) begin
            lcgState = nextRand(lcgState);
            resultReady = lcgState[28];
        end else begin
            resultReady = 1'b1;
        end
    end

    // Scoreboard; a transfer seen here completes at the next edge.
    always @(negedge clk) begin
        if (rstN && resultValid && resultReady) begin
            if (int'(resultTag) >= rowCount) begin
                errors++;
                $display("Result with tag %0d was never dispatched", resultTag);
            end else if (seen[resultTag]) begin
                errors++;
                $display("Result for tag %0d arrived twice", resultTag);
            end else begin
                seen[resultTag] = 1'b1;
                checkValue("resultValue", resultValue, stimTable[resultTag].exp);
            end
            resultCount++;
        end
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        dispValid = 1'b0;
        dispOpcode = OP_ADD;
        dispSrcA = '0;
        dispSrcB = '0;
        dispTag = '0;
        resultReady = 1'b0;
        errors = 0;
        resultCount = 0;
        rowCount = 0;
        readyMode = 0;
        lcgState = 32'hc445_4839;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;

        // Idle state after reset.
        @(negedge clk);
        checkValue("resultValid", 32'(resultValid), 32'd0);
        checkValue("dispReady", 32'(dispReady), 32'd1);
        @(posedge clk);
        #1;

        // All rows with the result port always ready.
        startTest(ROW_NUM);
        for (int r = 0; r < ROW_NUM; r++) dispatchRow(r);
        finishTest();

        // Result port held off; the unit fills to capacity.
        readyMode = 1;
        repeat (2) @(posedge clk);
        #1;
        startTest(CAPACITY);
        for (int r = 0; r < CAPACITY; r++) dispatchRow(r);
        repeat (8) begin
            @(negedge clk);
            checkValue("dispReady", 32'(dispReady), 32'd0);
        end
        @(posedge clk);
        #1;
        readyMode = 0;
        finishTest();

        // Random back-pressure.
        readyMode = 2;
        startTest(ROW_NUM);
        for (int r = 0; r < ROW_NUM; r++) dispatchRow(r);
        finishTest();

        reportAndFinish();
    end

endmodule : IssueUnitTb

//--- verification/IssueUnit_properties.sv
//////////////////////////////
// Issue unit properties.
// Handshake stability and issue grant sanity.
//////////////////////////////
`timescale 1ns/1ps

module IssueUnit_properties import IssuePkg::*; (
    input logic clk,
    input logic rstN,
    input logic resultValid,
    input logic [TAG_WIDTH-1:0] resultTag,
    input logic [DATA_WIDTH-1:0] resultValue,
    input logic resultReady,
    input logic [LANE_NUM-1:0] laneValid,
    input logic [LANE_NUM-1:0] laneReady,
    input logic [ENTRY_PTR_WIDTH-1:0] lanePtr[LANE_NUM],
    input IssueOp entryOp[ENTRY_NUM],
    input logic [ENTRY_NUM-1:0] entryValid
);

    // Payload seen by each lane.
    IssueOp laneOp[LANE_NUM];

    // Entries claimed by the lanes this cycle.
    logic [ENTRY_NUM-1:0] laneGrant;

    always_comb begin
        laneGrant = '0;
        for (int p = 0; p < LANE_NUM; p++) begin
            if (laneValid[p]) laneGrant[lanePtr[p]] = 1'b1;
        end
    end

    // A stalled result holds still.
    assert property (@(posedge clk) disable iff (!rstN)
        resultValid && !resultReady |=> resultValid && $stable(resultTag) && $stable(resultValue))
        else $error("result port changed while stalled");

    for (genvar p = 0; p < LANE_NUM; p++) begin : gLane
        assign laneOp[p] = entryOp[lanePtr[p]];

        assert property (@(posedge clk) disable iff (!rstN)
            laneValid[p] && !laneReady[p] |=> laneValid[p] && $stable(laneOp[p]))
            else $error("lane %0d issue payload changed while stalled", p);
    end

    // One distinct entry per valid lane, and only valid entries.
    assert property (@(posedge clk) disable iff (!rstN)
        $countones(laneGrant) == $countones(laneValid))
        else $error("two lanes selected the same entry");

    assert property (@(posedge clk) disable iff (!rstN) (laneGrant & ~entryValid) == '0)
        else $error("issue grant selects an empty entry");

endmodule : IssueUnit_properties

bind IssueUnit IssueUnit_properties i_IssueUnitProperties (
    .clk(clk),
    .rstN(rstN),
    .resultValid(resultValid),
    .resultTag(resultTag),
    .resultValue(resultValue),
    .resultReady(resultReady),
    .laneValid(i_IssueQueue.laneValid),
    .laneReady(i_IssueQueue.laneReady),
    .lanePtr(i_IssueQueue.lanePtr),
    .entryOp(i_IssueQueue.entryOp),
    .entryValid(i_IssueQueue.entryValid)
);
